// ==== Bender.yml ====
package:
  name: axis_ppfifo

sources:
  - source/stream_pkg.sv
  - source/ppfifo_pkg.sv
  - source/ppfifo_word_counter.sv
  - source/ppfifo_write_fsm.sv
  - source/ppfifo_banks.sv
  - source/axis_ppfifo_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_axis_ppfifo.sv

// ==== bench/tb_axis_ppfifo_tasks.svh ====
// LFSR source, value check, stream send and read drain tasks for the FIFO testbench
`ifndef TB_AXIS_PPFIFO_TASKS_SVH
`define TB_AXIS_PPFIFO_TASKS_SVH

// Galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic lsb;
  lsb = s[0];
  s   = s >> 1;
  if (lsb) begin
    s = s ^ 32'h8020_0003;
  end
  return s;
endfunction

// One step per bit, bits shifted in from the bottom
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    lfsr_state = lfsr_next(lfsr_state);
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string msg);
  if (actual !== expected) begin
    errors++;
    $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
  end
endtask

// Valid held until accepted, gaps only before a beat starts
task automatic send_block(input int n, input bit gaps);
  logic [31:0] word;
  int          idle;
  bit          taken;
  for (int i = 0; i < n; i++) begin
    if (gaps) begin
      idle = int'(take_bits(2));
      repeat (idle) begin
        @(negedge clk);
        i_axi_valid = 1'b0;
      end
    end
    word  = take_bits(stream_pkg::DATA_W);
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      i_axi_valid = 1'b1;
      i_axi_data  = word;
      i_axi_last  = (i == n - 1);
      // Ready does not depend on valid, accept lands on the next rising edge
      taken = o_axi_ready;
    end
    exp_words.push_back(word);
    // Bank closes on block end or a full bank
    exp_lasts.push_back((i == n - 1) ||
                        (i % ppfifo_pkg::BANK_DEPTH == ppfifo_pkg::BANK_DEPTH - 1));
  end
  @(negedge clk);
  i_axi_valid = 1'b0;
  i_axi_last  = 1'b0;
endtask

// Pops words until n banks have ended, word checked in the cycle it is popped
task automatic drain(input int n_banks, input bit gaps);
  int          banks_done;
  logic [31:0] exp_word;
  logic        exp_last;
  banks_done = 0;
  while (banks_done < n_banks) begin
    @(negedge clk);
    i_rd_stb = 1'b0;
    if (o_rd_valid && !(gaps && take_bits(1) == 1)) begin
      i_rd_stb = 1'b1;
      if (exp_words.size() == 0) begin
        errors++;
        $display("Read port offered a word that was never sent at %0t", $time);
      end else begin
        exp_word = exp_words.pop_front();
        exp_last = exp_lasts.pop_front();
        check(o_rd_data, exp_word, "read data");
        check(o_rd_last, exp_last, "read last flag");
        if (exp_last) begin
          banks_done++;
        end
      end
    end
  end
  @(negedge clk);
  i_rd_stb = 1'b0;
endtask

`endif

// ==== bench/tb_axis_ppfifo.sv ====
// Testbench top for the ping-pong FIFO with clock, reset, DUT, watchdog and directed tests
`timescale 1ns/1ps

module tb_axis_ppfifo;

  logic                          clk;
  logic                          rst;
  logic                          i_axi_valid;
  logic [stream_pkg::DATA_W-1:0] i_axi_data;
  logic                          i_axi_last;
  logic                          i_rd_stb;
  logic                          o_axi_ready;
  logic                          o_rd_valid;
  logic [stream_pkg::DATA_W-1:0] o_rd_data;
  logic                          o_rd_last;

  // Reference model of words in flight, oldest first
  logic [stream_pkg::DATA_W-1:0] exp_words [$];
  logic                          exp_lasts [$];

  int          errors = 0;
  int          cycles = 0;
  logic [31:0] lfsr_state;

  `include "tb_axis_ppfifo_tasks.svh"

  axis_ppfifo_top uut (
    .clk         (clk),
    .rst         (rst),
    .i_axi_valid (i_axi_valid),
    .i_axi_data  (i_axi_data),
    .i_axi_last  (i_axi_last),
    .i_rd_stb    (i_rd_stb),
    .o_axi_ready (o_axi_ready),
    .o_rd_valid  (o_rd_valid),
    .o_rd_data   (o_rd_data),
    .o_rd_last   (o_rd_last)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  // Watchdog, roughly five times the whole sequence
  initial begin
    wait (cycles >= 2000);
    $display("Run timed out after %0d cycles with %0d errors", cycles, errors);
    $display("Test FAILED");
    $finish;
  end

  // Nothing sent yet, ready only comes from bank activation
  task automatic reset_ready_test;
    int waited;
    check(o_axi_ready, 0, "ready right after reset");
    check(o_rd_valid, 0, "read valid right after reset");
    waited = 0;
    while (!o_axi_ready && waited < 5) begin
      @(negedge clk);
      waited++;
    end
    check(o_axi_ready, 1, "ready after bank activation");
  endtask

  // One short block, one bank
  task automatic short_block_test;
    send_block(5, 1'b0);
    drain(1, 1'b0);
  endtask

  // Block spills over into the second bank
  task automatic long_block_test;
    send_block(12, 1'b0);
    drain(2, 1'b0);
  endtask

  // Both banks full, third block must wait for a drain
  task automatic back_pressure_test;
    send_block(8, 1'b0);
    send_block(8, 1'b0);
    fork
      send_block(5, 1'b0);
      begin
        repeat (20) begin
          @(negedge clk);
          check(o_axi_ready, 0, "ready while both banks full");
        end
        drain(1, 1'b0);
      end
    join
    drain(2, 1'b0);
  endtask

  // Writer and reader run together with random stalls
  task automatic random_gap_test;
    fork
      begin
        for (int blk = 0; blk < 6; blk++) begin
          send_block(int'(take_bits(3)) + 1, 1'b1);
        end
      end
      drain(6, 1'b1);
    join
  endtask

  initial begin
    rst         = 1'b1;
    i_axi_valid = 1'b0;
    i_axi_data  = '0;
    i_axi_last  = 1'b0;
    i_rd_stb    = 1'b0;
    lfsr_state  = 32'd93701;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    reset_ready_test();
    short_block_test();
    long_block_test();
    back_pressure_test();
    random_gap_test();
    check(exp_words.size(), 0, "words left in the model");
    $display("Closing count: %0d errors after %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+bench
source/stream_pkg.sv
source/ppfifo_pkg.sv
source/ppfifo_word_counter.sv
source/ppfifo_write_fsm.sv
source/ppfifo_banks.sv
source/axis_ppfifo_top.sv
bench/tb_axis_ppfifo.sv

// ==== source/axis_ppfifo_top.sv ====
// Top level joining the write FSM, the word counter and the bank store
`timescale 1ns/1ps

module axis_ppfifo_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            i_axi_valid,
  input  logic [stream_pkg::DATA_W-1:0]   i_axi_data,
  input  logic                            i_axi_last,
  input  logic                            i_rd_stb,
  output logic                            o_axi_ready,
  output logic                            o_rd_valid,
  output logic [stream_pkg::DATA_W-1:0]   o_rd_data,
  output logic                            o_rd_last
);

  // Writer to store
  logic [ppfifo_pkg::NUM_BANKS-1:0] wr_act;
  logic                             wr_stb;
  logic [stream_pkg::DATA_W-1:0]    wr_data;
  logic [ppfifo_pkg::ADDR_W-1:0]    wr_addr;
  logic [ppfifo_pkg::NUM_BANKS-1:0] bank_rdy;

  // Writer and counter
  logic                             cnt_clr;
  logic                             cnt_inc;
  logic [ppfifo_pkg::CNT_W-1:0]     cnt;
  logic                             cnt_full;

  ppfifo_write_fsm u_write_fsm (
    .clk         (clk),
    .rst         (rst),
    .i_axi_valid (i_axi_valid),
    .i_axi_data  (i_axi_data),
    .i_axi_last  (i_axi_last),
    .i_bank_rdy  (bank_rdy),
    .i_cnt       (cnt),
    .i_full      (cnt_full),
    .o_axi_ready (o_axi_ready),
    .o_wr_act    (wr_act),
    .o_wr_stb    (wr_stb),
    .o_wr_data   (wr_data),
    .o_wr_addr   (wr_addr),
    .o_cnt_clr   (cnt_clr),
    .o_cnt_inc   (cnt_inc)
  );

  ppfifo_word_counter u_word_counter (
    .clk    (clk),
    .rst    (rst),
    .i_clr  (cnt_clr),
    .i_inc  (cnt_inc),
    .o_cnt  (cnt),
    .o_full (cnt_full)
  );

  // Live count doubles as the length latched on release
  ppfifo_banks u_banks (
    .clk        (clk),
    .rst        (rst),
    .i_wr_act   (wr_act),
    .i_wr_stb   (wr_stb),
    .i_wr_addr  (wr_addr),
    .i_wr_data  (wr_data),
    .i_wr_len   (cnt),
    .i_rd_stb   (i_rd_stb),
    .o_bank_rdy (bank_rdy),
    .o_rd_valid (o_rd_valid),
    .o_rd_data  (o_rd_data),
    .o_rd_last  (o_rd_last)
  );

endmodule

// ==== source/ppfifo_banks.sv ====
// Two-bank word store with fill lengths, ready flags and an in-order read port
`timescale 1ns/1ps

module ppfifo_banks (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [ppfifo_pkg::NUM_BANKS-1:0]    i_wr_act,
  input  logic                                i_wr_stb,
  input  logic [ppfifo_pkg::ADDR_W-1:0]       i_wr_addr,
  input  logic [stream_pkg::DATA_W-1:0]       i_wr_data,
  input  logic [ppfifo_pkg::CNT_W-1:0]        i_wr_len,
  input  logic                                i_rd_stb,
  output logic [ppfifo_pkg::NUM_BANKS-1:0]    o_bank_rdy,
  output logic                                o_rd_valid,
  output logic [stream_pkg::DATA_W-1:0]       o_rd_data,
  output logic                                o_rd_last
);

  // Word storage, one array per bank
  logic [stream_pkg::DATA_W-1:0] mem [ppfifo_pkg::NUM_BANKS][ppfifo_pkg::BANK_DEPTH];
  // Committed length per bank
  logic [ppfifo_pkg::CNT_W-1:0]  len [ppfifo_pkg::NUM_BANKS];

  logic [ppfifo_pkg::NUM_BANKS-1:0] act_q;
  logic [ppfifo_pkg::NUM_BANKS-1:0] fall;
  logic [ppfifo_pkg::NUM_BANKS-1:0] rdy;
  logic [ppfifo_pkg::NUM_BANKS-1:0] filled;
  logic                             rd_ptr;
  logic [ppfifo_pkg::ADDR_W-1:0]    rd_addr;
  logic                             pop;
  logic                             pop_last;

  // Bank released by the writer this cycle
  assign fall = act_q & ~i_wr_act;

  assign o_bank_rdy = rdy;

  // Read side looks only at the bank under the pointer
  assign o_rd_valid = filled[rd_ptr];
  assign o_rd_data  = mem[rd_ptr][rd_addr];
  assign o_rd_last  = o_rd_valid &&
                      ((ppfifo_pkg::CNT_W'(rd_addr) + ppfifo_pkg::CNT_W'(1)) == len[rd_ptr]);

  // Strobes without a valid word are dropped
  assign pop      = i_rd_stb && o_rd_valid;
  assign pop_last = pop && o_rd_last;

  // Word writes into the active bank
  // Act is still high during the final strobe
  always_ff @(posedge clk) begin
    for (int b = 0; b < ppfifo_pkg::NUM_BANKS; b++) begin
      if (i_wr_stb && i_wr_act[b]) begin
        mem[b][i_wr_addr] <= i_wr_data;
      end
      // Counter is stable once act drops
      if (fall[b]) begin
        len[b] <= i_wr_len;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      act_q   <= '0;
      rdy     <= '1;
      filled  <= '0;
      rd_ptr  <= 1'b0;
      rd_addr <= '0;
    end else begin
      act_q <= i_wr_act;

      // Read pointer walks words, then hands over to the other bank
      if (pop) begin
        if (pop_last) begin
          filled[rd_ptr] <= 1'b0;
          rdy[rd_ptr]    <= 1'b1;
          rd_ptr         <= !rd_ptr;
          rd_addr        <= '0;
        end else begin
          rd_addr <= rd_addr + 1'b1;
        end
      end

      for (int b = 0; b < ppfifo_pkg::NUM_BANKS; b++) begin
        // Busy while the writer holds it
        if (i_wr_act[b]) begin
          rdy[b] <= 1'b0;
        end
        if (fall[b]) begin
          if (i_wr_len == '0) begin
            // Nothing written, free it again right away
            rdy[b] <= 1'b1;
          end else begin
            filled[b] <= 1'b1;
            // Oldest bank first
            // With the other bank empty this one is next to read
            if (!filled[ppfifo_pkg::NUM_BANKS - 1 - b]) begin
              rd_ptr <= 1'(b);
            end
          end
        end
      end
    end
  end

endmodule

// ==== source/ppfifo_pkg.sv ====
// Ping-pong FIFO package with bank sizing, address and count widths, write states
package ppfifo_pkg;

  // Number of banks in the ping-pong store
  localparam int NUM_BANKS = 2;

  // Words per bank
  // Kept small so a block fills a bank quickly
  localparam int BANK_DEPTH = 8;

  // Word address inside one bank
  localparam int ADDR_W = $clog2(BANK_DEPTH);

  // Fill count, 0 up to BANK_DEPTH inclusive
  localparam int CNT_W = $clog2(BANK_DEPTH + 1);

  // Write FSM states
  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_ACTIVE  = 2'd1;
  localparam logic [1:0] ST_RELEASE = 2'd2;

endpackage

// ==== source/ppfifo_word_counter.sv ====
// Word counter of accepted beats per bank fill with a full flag
`timescale 1ns/1ps

module ppfifo_word_counter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_clr,
  input  logic                          i_inc,
  output logic [ppfifo_pkg::CNT_W-1:0]  o_cnt,
  output logic                          o_full
);

  // Full once a whole bank worth of beats is in
  assign o_full = (o_cnt == ppfifo_pkg::CNT_W'(ppfifo_pkg::BANK_DEPTH));

  always_ff @(posedge clk) begin
    if (rst) begin
      o_cnt <= '0;
    end else if (i_clr) begin
      // New bank, start from word 0
      o_cnt <= '0;
    end else if (i_inc && !o_full) begin
      // Saturate at depth
      o_cnt <= o_cnt + 1'b1;
    end
  end

  // Count also serves as the committed bank length
  // It holds steady from the last beat until the next clear

endmodule

// ==== source/ppfifo_write_fsm.sv ====
// Write FSM that picks a free bank, accepts stream beats into it and releases it
`timescale 1ns/1ps

module ppfifo_write_fsm (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_axi_valid,
  input  logic [stream_pkg::DATA_W-1:0]       i_axi_data,
  input  logic                                i_axi_last,
  input  logic [ppfifo_pkg::NUM_BANKS-1:0]    i_bank_rdy,
  input  logic [ppfifo_pkg::CNT_W-1:0]        i_cnt,
  input  logic                                i_full,
  output logic                                o_axi_ready,
  output logic [ppfifo_pkg::NUM_BANKS-1:0]    o_wr_act,
  output logic                                o_wr_stb,
  output logic [stream_pkg::DATA_W-1:0]       o_wr_data,
  output logic [ppfifo_pkg::ADDR_W-1:0]       o_wr_addr,
  output logic                                o_cnt_clr,
  output logic                                o_cnt_inc
);

  logic [1:0] state;
  logic       accept;
  logic       release_now;

  // Ready only while filling and the bank still has room
  // RELEASE is excluded so no beat slips in after the last one
  assign o_axi_ready = (state == ppfifo_pkg::ST_ACTIVE) && (|o_wr_act) && !i_full;
  assign accept      = i_axi_valid && o_axi_ready;

  // Count is pre-increment here
  // Depth minus one means this beat fills the bank
  assign release_now = accept &&
                       (i_axi_last ||
                        (i_cnt == ppfifo_pkg::CNT_W'(ppfifo_pkg::BANK_DEPTH - 1)));

  // Counter clears on the same edge that raises act
  assign o_cnt_clr = (state == ppfifo_pkg::ST_IDLE) && (o_wr_act == '0) && (|i_bank_rdy);
  assign o_cnt_inc = accept;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ppfifo_pkg::ST_IDLE;
      o_wr_act <= '0;
      o_wr_stb <= 1'b0;
    end else begin
      // One strobe per accepted beat one cycle later
      o_wr_stb <= accept;
      case (state)
        ppfifo_pkg::ST_IDLE: begin
          if (o_cnt_clr) begin
            // Bank 0 wins when both are free
            o_wr_act[0] <= i_bank_rdy[0];
            o_wr_act[1] <= !i_bank_rdy[0];
            state       <= ppfifo_pkg::ST_ACTIVE;
          end
        end
        ppfifo_pkg::ST_ACTIVE: begin
          // Last beat or full bank ends the fill
          if (release_now) begin
            state <= ppfifo_pkg::ST_RELEASE;
          end
        end
        ppfifo_pkg::ST_RELEASE: begin
          // Act falls here
          // Banks commit on seeing the drop
          o_wr_act <= '0;
          state    <= ppfifo_pkg::ST_IDLE;
        end
        default: begin
          o_wr_act <= '0;
          state    <= ppfifo_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Beat payload and its bank address
  // Aligned with o_wr_stb
  always_ff @(posedge clk) begin
    if (accept) begin
      o_wr_data <= i_axi_data;
      o_wr_addr <= i_cnt[ppfifo_pkg::ADDR_W-1:0];
    end
  end

endmodule

// ==== source/stream_pkg.sv ====
// Stream package with the beat width shared by the RTL and the testbench
package stream_pkg;

  // Width of one stream beat in bits
  // A bank word is exactly one beat wide
  localparam int DATA_W = 32;

  // Keep lanes are not carried
  // Every beat is taken as a full word

endpackage
